//--- include/evt_macros.svh
/*
 * field widths of the event capture queue
 * default FIFO depth
 */

`ifndef EVT_MACROS_SVH
`define EVT_MACROS_SVH

// event fields
`define EVT_TAG_W     8
`define EVT_PAYLOAD_W 16

// stamping fields
`define EVT_SEQ_W     8
`define EVT_STAMP_W   32

// records held between input and output side
`define EVT_FIFO_DEPTH 4

`endif

//--- src/evt_pkg.sv
/*
 * event, stamped record and output beat types
 * output beat union, header and timestamp decodings
 */

`default_nettype none

`include "evt_macros.svh"

package evt_pkg;

  // event as handed in by a source
  typedef struct packed {
    logic [`EVT_TAG_W-1:0]     tag;
    logic [`EVT_PAYLOAD_W-1:0] payload;
  } evt_t;

  // event after stamping, as held in the FIFO
  typedef struct packed {
    logic [`EVT_SEQ_W-1:0]     seq;
    logic [`EVT_TAG_W-1:0]     tag;
    logic [`EVT_PAYLOAD_W-1:0] payload;
    logic [`EVT_STAMP_W-1:0]   stamp;
  } rec_t;

  localparam int unsigned REC_W = $bits(rec_t);

  // first beat of a record
  typedef struct packed {
    logic                      is_hdr;
    logic [`EVT_SEQ_W-1:0]     seq;
    logic [`EVT_TAG_W-1:0]     tag;
    logic [`EVT_PAYLOAD_W-1:0] payload;
  } hdr_beat_t;

  // second beat of a record
  typedef struct packed {
    logic                    is_hdr;
    logic [`EVT_STAMP_W-1:0] stamp;
  } ts_beat_t;

  // top bit tells which view is valid
  typedef union packed {
    hdr_beat_t hdr;
    ts_beat_t  ts;
  } out_beat_u;

endpackage

`default_nettype wire

//--- src/evt_stamp.sv
/*
 * input side of the event queue
 * free-running cycle counter, sequence counter, record build
 */

`default_nettype none

`include "evt_macros.svh"

module evt_stamp (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic        flush_i,
  // event source
  input  wire logic        evt_valid_i,
  input  evt_pkg::evt_t    evt_i,
  // towards the FIFO write port
  output logic             rec_valid_o,
  input  wire logic        rec_ready_i,
  output evt_pkg::rec_t    rec_o
);

  logic [`EVT_STAMP_W-1:0] stamp_q;
  logic [`EVT_SEQ_W-1:0]   seq_q;
  logic                    accept;

  assign accept = evt_valid_i & rec_ready_i;

  // cycle count, runs through flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stamp_q <= '0;
    end else begin
      stamp_q <= stamp_q + `EVT_STAMP_W'(1);
    end
  end

  // one step per accepted event, wraps naturally
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= '0;
    end else if (flush_i) begin
      seq_q <= '0;
    end else if (accept) begin
      seq_q <= seq_q + `EVT_SEQ_W'(1);
    end
  end

  // record carries the count of the accept cycle
  assign rec_valid_o = evt_valid_i;
  assign rec_o = '{
    seq:     seq_q,
    tag:     evt_i.tag,
    payload: evt_i.payload,
    stamp:   stamp_q
  };

endmodule

`default_nettype wire

//--- src/evt_fifo.sv
/*
 * synchronous FIFO with wrap-bit pointers
 * optional pass-through when empty, synchronous clear, occupancy
 */

`default_nettype none

module evt_fifo #(
  parameter int unsigned Width  = 16,
  parameter int unsigned Depth  = 4,
  parameter bit          Pass   = 1'b1,
  localparam int unsigned DepthW = $clog2(Depth + 1)
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              clr_i,
  // write side
  input  wire logic              wvalid_i,
  output logic                   wready_o,
  input  wire logic [Width-1:0]  wdata_i,
  // read side
  output logic                   rvalid_o,
  input  wire logic              rready_i,
  output logic [Width-1:0]       rdata_o,
  // records held
  output logic [DepthW-1:0]      depth_o
);

  localparam int unsigned AddrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned PtrW  = AddrW + 1;

  logic [PtrW-1:0]  wptr_q, rptr_q;
  logic [AddrW-1:0] waddr, raddr;
  logic             wwrap, rwrap;
  logic             full, mem_empty, empty;
  logic             push, pop;

  logic [Width-1:0] mem_q [Depth];
  logic [Width-1:0] mem_rdata;

  assign waddr = wptr_q[AddrW-1:0];
  assign raddr = rptr_q[AddrW-1:0];
  assign wwrap = wptr_q[PtrW-1];
  assign rwrap = rptr_q[PtrW-1];

  // same address, opposite wrap bit means every slot is taken
  assign full      = (waddr == raddr) && (wwrap != rwrap);
  assign mem_empty = (wptr_q == rptr_q);

  // clear wins over both handshakes
  assign wready_o = ~full & ~clr_i;
  assign rvalid_o = ~empty & ~clr_i;

  assign push = wvalid_i & wready_o;
  assign pop  = rvalid_o & rready_i;

  assign depth_o = full          ? DepthW'(Depth) :
                   (wwrap == rwrap) ? DepthW'(waddr) - DepthW'(raddr) :
                   DepthW'(Depth) - DepthW'(raddr) + DepthW'(waddr);

  ////////////////////////////////////////////////////////////////////////////
  // pointers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
    end else if (clr_i) begin
      wptr_q <= '0;
    end else if (push) begin
      // last slot: back to zero with the wrap bit flipped
      if (waddr == AddrW'(Depth - 1)) begin
        wptr_q <= {~wwrap, {AddrW{1'b0}}};
      end else begin
        wptr_q <= wptr_q + PtrW'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rptr_q <= '0;
    end else if (clr_i) begin
      rptr_q <= '0;
    end else if (pop) begin
      if (raddr == AddrW'(Depth - 1)) begin
        rptr_q <= {~rwrap, {AddrW{1'b0}}};
      end else begin
        rptr_q <= rptr_q + PtrW'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[waddr] <= wdata_i;
    end
  end

  assign mem_rdata = mem_q[raddr];

  if (Pass) begin : gen_pass
    // incoming word seen at the read side while the array is empty
    assign empty   = mem_empty & ~wvalid_i;
    assign rdata_o = mem_empty ? wdata_i : mem_rdata;
  end else begin : gen_no_pass
    assign empty   = mem_empty;
    assign rdata_o = mem_rdata;
  end

endmodule

`default_nettype wire

//--- src/evt_drain.sv
/*
 * output side of the event queue
 * two beats per record, header first, then timestamp
 */

`default_nettype none

module evt_drain (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  // from the FIFO read port
  input  wire logic          rec_valid_i,
  output logic               rec_ready_o,
  input  evt_pkg::rec_t      rec_i,
  // beat stream out
  output logic               out_valid_o,
  input  wire logic          out_ready_i,
  output evt_pkg::out_beat_u out_o
);

  // 0 header beat, 1 timestamp beat
  logic phase_q, phase_d;

  assign out_valid_o = rec_valid_i;

  // record leaves the FIFO with its second beat
  assign rec_ready_o = phase_q & out_ready_i;

  always_comb begin
    phase_d = phase_q;
    if (!rec_valid_i) begin
      // record gone, e.g. after a flush, so start over on a header
      phase_d = 1'b0;
    end else if (out_ready_i) begin
      phase_d = ~phase_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= 1'b0;
    end else begin
      phase_q <= phase_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // beat build
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (!phase_q) begin
      out_o.hdr = '{
        is_hdr:  1'b1,
        seq:     rec_i.seq,
        tag:     rec_i.tag,
        payload: rec_i.payload
      };
    end else begin
      out_o.ts = '{
        is_hdr: 1'b0,
        stamp:  rec_i.stamp
      };
    end
  end

endmodule

`default_nettype wire

//--- src/evt_queue_top.sv
/*
 * event capture queue top level
 * stamp block, record FIFO and beat drain
 */

`default_nettype none

`include "evt_macros.svh"

module evt_queue_top #(
  localparam int unsigned LevelW = $clog2(`EVT_FIFO_DEPTH + 1)
) (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  input  wire logic          flush_i,
  // event source
  input  wire logic          evt_valid_i,
  output logic               evt_ready_o,
  input  evt_pkg::evt_t      evt_i,
  // beat sink
  output logic               out_valid_o,
  input  wire logic          out_ready_i,
  output evt_pkg::out_beat_u out_o,
  // records waiting
  output logic [LevelW-1:0]  level_o
);

  logic          wvalid;
  evt_pkg::rec_t wrec;
  logic          rvalid;
  logic          rready;
  evt_pkg::rec_t rrec;

  evt_stamp u_stamp (
    .clk_i,
    .rst_ni,
    .flush_i,
    .evt_valid_i,
    .evt_i,
    .rec_valid_o (wvalid),
    .rec_ready_i (evt_ready_o),
    .rec_o       (wrec)
  );

  evt_fifo #(
    .Width (evt_pkg::REC_W),
    .Depth (`EVT_FIFO_DEPTH),
    .Pass  (1'b1)
  ) u_fifo (
    .clk_i,
    .rst_ni,
    .clr_i    (flush_i),
    .wvalid_i (wvalid),
    .wready_o (evt_ready_o),
    .wdata_i  (wrec),
    .rvalid_o (rvalid),
    .rready_i (rready),
    .rdata_o  (rrec),
    .depth_o  (level_o)
  );

  evt_drain u_drain (
    .clk_i,
    .rst_ni,
    .rec_valid_i (rvalid),
    .rec_ready_o (rready),
    .rec_i       (rrec),
    .out_valid_o,
    .out_ready_i,
    .out_o
  );

endmodule

`default_nettype wire

//--- test/evt_queue_props.sv
/*
 * concurrent checks on the event queue top-level ports
 * stall stability, level bound, full back-pressure, beat order
 */

`default_nettype none

`include "evt_macros.svh"

module evt_queue_props (
  input wire logic                                       clk_i,
  input wire logic                                       rst_ni,
  input wire logic                                       flush_i,
  input wire logic                                       evt_ready_o,
  input wire logic                                       out_valid_o,
  input wire logic                                       out_ready_i,
  input evt_pkg::out_beat_u                              out_o,
  input wire logic [$clog2(`EVT_FIFO_DEPTH + 1)-1:0]     level_o
);

  // a stalled beat holds until taken, unless flushed away
  stall_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i && !flush_i |=> flush_i || (out_valid_o && $stable(out_o)))
    else $error("beat changed while stalled");

  level_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    level_o <= `EVT_FIFO_DEPTH)
    else $error("level above FIFO depth");

  full_holds_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
    level_o == `EVT_FIFO_DEPTH |-> !evt_ready_o)
    else $error("source accepted while FIFO full");

  // header accepted, timestamp next
  ts_after_hdr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && out_ready_i && out_o.hdr.is_hdr
      |=> flush_i || (out_valid_o && !out_o.hdr.is_hdr))
    else $error("header beat not followed by a timestamp beat");

endmodule

bind evt_queue_top evt_queue_props u_props (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .flush_i     (flush_i),
  .evt_ready_o (evt_ready_o),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .out_o       (out_o),
  .level_o     (level_o)
);

`default_nettype wire

//--- test/tb_evt_queue.sv
/*
 * directed testbench for the event capture queue
 * clock, reset, beat monitor, ready driver, tests, summary
 */

`default_nettype none

`include "evt_macros.svh"

module tb_evt_queue;

  localparam int unsigned LevelW    = $clog2(`EVT_FIFO_DEPTH + 1);
  localparam int          WaitLimit = 200;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 flush_i;
  logic                 evt_valid_i;
  logic                 evt_ready_o;
  evt_pkg::evt_t        evt_i;
  logic                 out_valid_o;
  logic                 out_ready_i;
  evt_pkg::out_beat_u   out_o;
  logic [LevelW-1:0]    level_o;

  int seed;
  int cyc;
  int rst_cyc;
  int rnd_ready;
  bit stall_en;
  bit ready_set;
  int value_errors;
  int timeouts;
  int other_errors;

  logic [`EVT_SEQ_W-1:0] exp_seq;
  evt_pkg::hdr_beat_t    exp_hdr_q[$];
  int                    acc_q[$];
  evt_pkg::out_beat_u    beat_q[$];

  evt_queue_top evt_queue_top_i (
    .clk_i,
    .rst_ni,
    .flush_i,
    .evt_valid_i,
    .evt_ready_o,
    .evt_i,
    .out_valid_o,
    .out_ready_i,
    .out_o,
    .level_o
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  // beats taken at the coming edge are sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni && out_valid_o && out_ready_i) begin
      beat_q.push_back(out_o);
    end
  end

  // sink ready follows a fixed level or random stalls
  always begin
    @(posedge clk_i);
    #5;
    rnd_ready = $random(seed);
    out_ready_i = stall_en ? rnd_ready[0] : ready_set;
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_hdr(input evt_pkg::hdr_beat_t got, input evt_pkg::hdr_beat_t exp,
                             input string what);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %0t %s: header beat %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_ts(input evt_pkg::ts_beat_t got, input evt_pkg::ts_beat_t exp,
                            input string what);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %0t %s: timestamp beat %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_level(input logic [LevelW-1:0] got, input logic [LevelW-1:0] exp,
                               input string what);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %0t %s: level %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %0t %s: flag %b, expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic step(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #10;
    end
  endtask

  task automatic set_ready(input bit lvl);
    stall_en = 1'b0;
    ready_set = lvl;
    step(1);
  endtask

  task automatic send_event(input evt_pkg::evt_t e);
    int waited;
    waited = 0;
    evt_valid_i = 1'b1;
    evt_i = e;
    @(negedge clk_i);
    while (!evt_ready_o && waited < WaitLimit) begin
      @(negedge clk_i);
      waited++;
    end
    if (!evt_ready_o) begin
      timeouts++;
      $display("timeout: event %h was never accepted", e);
    end else begin
      exp_hdr_q.push_back('{is_hdr: 1'b1, seq: exp_seq, tag: e.tag, payload: e.payload});
      acc_q.push_back(cyc);
      exp_seq++;
    end
    @(posedge clk_i);
    #10;
    evt_valid_i = 1'b0;
  endtask

  task automatic wait_beats(input int n, input string what);
    int waited;
    waited = 0;
    while (beat_q.size() < n && waited < WaitLimit) begin
      step(1);
      waited++;
    end
    if (beat_q.size() < n) begin
      timeouts++;
      $display("timeout: %s saw %0d of %0d beats", what, beat_q.size(), n);
    end
  endtask

  // headers in order and stamps equal to the cycles counted since reset
  task automatic check_records(input string what);
    evt_pkg::out_beat_u hb;
    evt_pkg::out_beat_u sb;
    evt_pkg::ts_beat_t  exp_t;
    int                 cy;
    while (exp_hdr_q.size() > 0) begin
      if (beat_q.size() < 2) begin
        other_errors++;
        $display("%s: %0d records never came out", what, exp_hdr_q.size());
        exp_hdr_q.delete();
        acc_q.delete();
        break;
      end
      hb = beat_q.pop_front();
      sb = beat_q.pop_front();
      cy = acc_q.pop_front();
      exp_t = '{is_hdr: 1'b0, stamp: `EVT_STAMP_W'(cy - rst_cyc)};
      compare_hdr(hb.hdr, exp_hdr_q.pop_front(), what);
      compare_ts(sb.ts, exp_t, what);
    end
  endtask

  task automatic check_idle(input string what);
    step(4);
    @(negedge clk_i);
    compare_level(level_o, '0, what);
    compare_flag(out_valid_o, 1'b0, what);
    if (beat_q.size() != 0) begin
      other_errors++;
      $display("%s: %0d unexpected extra beats", what, beat_q.size());
      beat_q.delete();
    end
    @(posedge clk_i);
    #10;
  endtask

  function automatic evt_pkg::evt_t random_event();
    int r;
    r = $random(seed);
    return evt_pkg::evt_t'(r[23:0]);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_single();
    set_ready(1'b1);
    send_event('{tag: 8'h5a, payload: 16'hbeef});
    wait_beats(2, "single");
    check_records("single");
    check_idle("single idle");
  endtask

  task automatic test_burst();
    evt_pkg::evt_t e;
    int            i;
    set_ready(1'b0);
    for (i = 0; i < 4; i++) begin
      e.tag = 8'(32'h20 + i);
      e.payload = 16'(i * 32'h0101);
      send_event(e);
    end
    // fifth event held off by a full FIFO
    evt_valid_i = 1'b1;
    evt_i = '{tag: 8'h24, payload: 16'h0404};
    @(negedge clk_i);
    compare_level(level_o, LevelW'(`EVT_FIFO_DEPTH), "burst full");
    compare_flag(evt_ready_o, 1'b0, "burst ready");
    @(posedge clk_i);
    #10;
    set_ready(1'b1);
    send_event('{tag: 8'h24, payload: 16'h0404});
    send_event('{tag: 8'h25, payload: 16'h0505});
    wait_beats(12, "burst");
    check_records("burst");
    check_idle("burst idle");
  endtask

  task automatic test_stalls();
    int i;
    stall_en = 1'b1;
    step(1);
    for (i = 0; i < 20; i++) begin
      send_event(random_event());
    end
    wait_beats(40, "stalls");
    set_ready(1'b1);
    check_records("stalls");
    check_idle("stalls idle");
  endtask

  task automatic test_stamps();
    int gaps[5] = '{0, 3, 1, 5, 2};
    int i;
    set_ready(1'b1);
    for (i = 0; i < 5; i++) begin
      step(gaps[i]);
      send_event(random_event());
    end
    wait_beats(10, "stamps");
    check_records("stamps");
    check_idle("stamps idle");
  endtask

  task automatic test_flush();
    int i;
    set_ready(1'b0);
    for (i = 0; i < 3; i++) begin
      send_event(random_event());
    end
    @(negedge clk_i);
    compare_level(level_o, LevelW'(3), "before flush");
    @(posedge clk_i);
    #10;
    flush_i = 1'b1;
    @(negedge clk_i);
    compare_flag(out_valid_o, 1'b0, "during flush");
    @(posedge clk_i);
    #10;
    flush_i = 1'b0;
    @(negedge clk_i);
    compare_level(level_o, '0, "after flush");
    compare_flag(out_valid_o, 1'b0, "after flush");
    @(posedge clk_i);
    #10;
    // flushed records are gone and seq restarts
    exp_hdr_q.delete();
    acc_q.delete();
    exp_seq = '0;
    set_ready(1'b1);
    send_event('{tag: 8'h77, payload: 16'h1234});
    wait_beats(2, "flush");
    check_records("flush");
    check_idle("flush idle");
  endtask

  initial begin
    seed = 46;
    cyc = 0;
    rst_cyc = 0;
    stall_en = 1'b0;
    ready_set = 1'b0;
    value_errors = 0;
    timeouts = 0;
    other_errors = 0;
    exp_seq = '0;
    rst_ni = 1'b0;
    flush_i = 1'b0;
    evt_valid_i = 1'b0;
    evt_i = '0;
    out_ready_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    // stamp counter sits at zero until the next edge
    rst_cyc = cyc;
    @(negedge clk_i);
    compare_flag(evt_ready_o, 1'b1, "after reset");
    compare_flag(out_valid_o, 1'b0, "after reset");
    compare_level(level_o, '0, "after reset");
    @(posedge clk_i);
    #10;
    test_single();
    test_burst();
    test_stalls();
    test_stamps();
    test_flush();
    $display("errors: %0d wrong values, %0d timeouts, %0d other", value_errors, timeouts,
             other_errors);
    if (value_errors + timeouts + other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
src/evt_pkg.sv
src/evt_stamp.sv
src/evt_fifo.sv
src/evt_drain.sv
src/evt_queue_top.sv
test/evt_queue_props.sv
test/tb_evt_queue.sv

//--- Bender.yml
package:
  name: evt_queue

export_include_dirs:
  - include

sources:
  - src/evt_pkg.sv
  - src/evt_stamp.sv
  - src/evt_fifo.sv
  - src/evt_drain.sv
  - src/evt_queue_top.sv
  - target: test
    files:
      - test/evt_queue_props.sv
      - test/tb_evt_queue.sv
